//--- verilog/slicer_cfg.svh
// slicer configuration
// fruit count, raster limits and the fixed colors of blade and fruits

`ifndef SLICER_CFG_SVH
`define SLICER_CFG_SVH

// ------------------------------------------------------------
// object counts
// ------------------------------------------------------------

`define NUM_FRUITS 3        // fruit slots, 1 to 8 supported

// ------------------------------------------------------------
// raster limits
// ------------------------------------------------------------

`define SCREEN_W 640        // visible pixels per line
`define SCREEN_H 480        // visible lines per frame

// ------------------------------------------------------------
// blade color
// ------------------------------------------------------------

`define CURSOR_RED   8'hff  // orange blade
`define CURSOR_GREEN 8'h55
`define CURSOR_BLUE  8'h00

// ------------------------------------------------------------
// fruit colors, slots above 2 reuse these cyclically
// ------------------------------------------------------------

`define FRUIT_RED_0   8'hff // fruit 0, pink
`define FRUIT_GREEN_0 8'h6f
`define FRUIT_BLUE_0  8'h6f

`define FRUIT_RED_1   8'h00 // fruit 1, cyan
`define FRUIT_GREEN_1 8'hff
`define FRUIT_BLUE_1  8'hff

`define FRUIT_RED_2   8'h94 // fruit 2, purple
`define FRUIT_GREEN_2 8'h3e
`define FRUIT_BLUE_2  8'ha2

`endif

//--- verilog/slicerPkg.sv
// slicer types
// width typedefs and the disk hit test shared by blade and fruit logic

`default_nettype none

package slicerPkg;

    typedef logic [9:0]  coordT;    // pixel or object position
    typedef logic [9:0]  radiusT;   // object radius
    typedef logic [7:0]  colorT;    // one color channel
    typedef logic [9:0]  scoreT;    // score, wraps at 1024
    typedef logic [21:0] distSqT;   // squared distance, sum of two squares

    // ------------------------------------------------------------
    // point inside disk: dx^2 + dy^2 <= r^2
    // ------------------------------------------------------------
    function automatic logic inDisk(
        input coordT  px,
        input coordT  py,
        input coordT  cx,
        input coordT  cy,
        input radiusT r
    );
        coordT  dx;   // |px - cx|
        coordT  dy;   // |py - cy|
        distSqT dSq;  // squared distance
        distSqT rSq;  // squared radius
        dx  = (px >= cx) ? px - cx : cx - px;  // unsigned abs diff
        dy  = (py >= cy) ? py - cy : cy - py;
        dSq = distSqT'(dx) * distSqT'(dx) + distSqT'(dy) * distSqT'(dy);
        rSq = distSqT'(r) * distSqT'(r);
        return dSq <= rSq;
    endfunction

endpackage

`default_nettype wire

//--- verilog/cursorProbe.sv
// blade probe
// tests each pixel against the blade disk and registers hit and play level

`default_nettype none

module cursorProbe import slicerPkg::*;
(
    input  logic   Clk,
    input  logic   resetf0,
    input  logic   throwFruit,   // play level, sampled with the pixel
    input  coordT  DrawX,
    input  coordT  DrawY,
    input  coordT  BallX,        // blade center
    input  coordT  BallY,
    input  radiusT BallSize,     // blade radius
    output logic   bladeOn,      // stage 1, blade covers pixel during play
    output logic   playOn        // stage 1, play level of that pixel
);

    logic bladeHit;  // raw disk test, stage 0

    // ------------------------------------------------------------
    // stage 0 hit test
    // ------------------------------------------------------------

    assign bladeHit = inDisk(DrawX, DrawY, BallX, BallY, BallSize);

    // ------------------------------------------------------------
    // stage 1 registers
    // ------------------------------------------------------------

    always_ff @(posedge Clk)
    begin
        if (resetf0)
        begin
            bladeOn <= 1'b0;
            playOn  <= 1'b0;
        end
        else
        begin
            bladeOn <= bladeHit & throwFruit;  // blade only counts in play
            playOn  <= throwFruit;             // follows its pixel
        end
    end

endmodule

`default_nettype wire

//--- verilog/fruitSlot.sv
// fruit slot
// one fruit's hit test, its sliced flag and the one-cycle slice pulse

`default_nettype none

module fruitSlot import slicerPkg::*;
(
    input  logic   Clk,
    input  logic   resetf0,
    input  logic   bladeOn,      // stage 1 blade hit
    input  logic   playOn,       // stage 1 play level
    input  logic   offstage,     // fruit left the stage, clears sliced
    input  coordT  DrawX,
    input  coordT  DrawY,
    input  coordT  fruitX,       // fruit center
    input  coordT  fruitY,
    input  radiusT fruitSize,    // fruit radius
    output logic   fruitShown,   // stage 1, fruit paints this pixel
    output logic   slicePulse,   // one cycle, fruit just became sliced
    output logic   sliced        // fruit is cut
);

    logic fruitHit;   // raw disk test, stage 0
    logic fruitHitQ;  // stage 1 disk hit
    logic cut;        // blade and fruit on same pixel

    // ------------------------------------------------------------
    // stage 0 hit test
    // ------------------------------------------------------------

    assign fruitHit = inDisk(DrawX, DrawY, fruitX, fruitY, fruitSize);

    always_ff @(posedge Clk)
    begin
        if (resetf0)
        begin
            fruitHitQ <= 1'b0;
        end
        else
        begin
            fruitHitQ <= fruitHit;  // aligned with bladeOn
        end
    end

    // ------------------------------------------------------------
    // stage 1 cut and visibility
    // ------------------------------------------------------------

    assign cut = fruitHitQ & bladeOn;  // bladeOn already carries play

    // hidden once sliced, and the blade draws over it
    assign fruitShown = fruitHitQ & playOn & ~sliced & ~bladeOn;

    // ------------------------------------------------------------
    // sliced flag and pulse
    // ------------------------------------------------------------

    always_ff @(posedge Clk)
    begin
        if (resetf0)
        begin
            sliced     <= 1'b0;
            slicePulse <= 1'b0;
        end
        else
        begin
            if (offstage)
            begin
                sliced <= 1'b0;  // leaving the stage wins over a cut
            end
            else if (cut)
            begin
                sliced <= 1'b1;
            end
            slicePulse <= cut & ~sliced & ~offstage;  // first cut only
        end
    end

    // a blade seen outside play would cut with the game stopped
    cutNeedsPlay: assert property (
        @(posedge Clk) disable iff (resetf0)
        bladeOn |-> playOn
    );

endmodule

`default_nettype wire

//--- verilog/sceneMixer.sv
// scene mixer
// picks blade, fruit or background color per pixel and keeps the score

`default_nettype none

`include "slicer_cfg.svh"

module sceneMixer import slicerPkg::*;
(
    input  logic                   Clk,
    input  logic                   resetf0,
    input  logic                   bladeOn,     // stage 1 blade hit
    input  logic [`NUM_FRUITS-1:0] fruitShown,  // stage 1 visible fruit per slot
    input  logic [`NUM_FRUITS-1:0] slicePulse,  // new slices this cycle
    input  colorT                  BkgRed,      // background, stage 0
    input  colorT                  BkgGreen,
    input  colorT                  BkgBlue,
    output colorT                  Red,         // pixel color, stage 2
    output colorT                  Green,
    output colorT                  Blue,
    output scoreT                  score
);

    // fruit palette, indexed by slot modulo 3
    localparam colorT fruitRedTab   [3] = '{`FRUIT_RED_0, `FRUIT_RED_1, `FRUIT_RED_2};
    localparam colorT fruitGreenTab [3] = '{`FRUIT_GREEN_0, `FRUIT_GREEN_1, `FRUIT_GREEN_2};
    localparam colorT fruitBlueTab  [3] = '{`FRUIT_BLUE_0, `FRUIT_BLUE_1, `FRUIT_BLUE_2};

    colorT bkgRedD;    // background aligned to stage 1
    colorT bkgGreenD;
    colorT bkgBlueD;
    colorT nextRed;    // selected color, stage 1
    colorT nextGreen;
    colorT nextBlue;
    scoreT scoreReg;   // slices counted before this cycle
    logic  anyPulse;   // at least one fruit sliced

    // ------------------------------------------------------------
    // background delay
    // ------------------------------------------------------------

    always_ff @(posedge Clk)
    begin
        bkgRedD   <= BkgRed;
        bkgGreenD <= BkgGreen;
        bkgBlueD  <= BkgBlue;
    end

    // ------------------------------------------------------------
    // color priority: blade, lowest visible fruit, background
    // ------------------------------------------------------------

    always_comb
    begin
        nextRed   = bkgRedD;
        nextGreen = bkgGreenD;
        nextBlue  = bkgBlueD;
        for (int i = `NUM_FRUITS - 1; i >= 0; i--)  // lower slot overrides
        begin
            if (fruitShown[i])
            begin
                nextRed   = fruitRedTab[i % 3];
                nextGreen = fruitGreenTab[i % 3];
                nextBlue  = fruitBlueTab[i % 3];
            end
        end
        if (bladeOn)
        begin
            nextRed   = `CURSOR_RED;  // blade on top
            nextGreen = `CURSOR_GREEN;
            nextBlue  = `CURSOR_BLUE;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (resetf0)
        begin
            Red   <= '0;
            Green <= '0;
            Blue  <= '0;
        end
        else
        begin
            Red   <= nextRed;
            Green <= nextGreen;
            Blue  <= nextBlue;
        end
    end

    // ------------------------------------------------------------
    // score
    // ------------------------------------------------------------

    assign anyPulse = |slicePulse;

    always_ff @(posedge Clk)
    begin
        if (resetf0)
        begin
            scoreReg <= '0;
        end
        else
        begin
            scoreReg <= scoreReg + scoreT'(anyPulse);  // wraps at 1024
        end
    end

    // pulse folded in so the new score shows on the slicing edge
    assign score = scoreReg + scoreT'(anyPulse);

    // a held pulse would score one slice twice
    pulseSingleCycle: assert property (
        @(posedge Clk) disable iff (resetf0)
        (slicePulse & $past(slicePulse)) == '0
    );

endmodule

`default_nettype wire

//--- verilog/sliceTop.sv
// slicer top level
// blade probe, one slot per fruit and the color mixer, two-stage pipeline

`default_nettype none

`include "slicer_cfg.svh"

module sliceTop import slicerPkg::*;
(
    input  logic                   Clk,
    input  logic                   resetf0,
    input  coordT                  DrawX,                    // current pixel
    input  coordT                  DrawY,
    input  coordT                  BallX,                    // blade
    input  coordT                  BallY,
    input  radiusT                 BallSize,
    input  coordT                  fruitX    [`NUM_FRUITS],  // fruits
    input  coordT                  fruitY    [`NUM_FRUITS],
    input  radiusT                 fruitSize [`NUM_FRUITS],
    input  logic [`NUM_FRUITS-1:0] offstage,
    input  logic                   throwFruit,               // play level
    input  colorT                  BkgRed,                   // background pixel
    input  colorT                  BkgGreen,
    input  colorT                  BkgBlue,
    output colorT                  Red,
    output colorT                  Green,
    output colorT                  Blue,
    output scoreT                  score,
    output logic [`NUM_FRUITS-1:0] sliced
);

    logic                   bladeOn;     // stage 1 blade hit
    logic                   playOn;      // stage 1 play level
    logic [`NUM_FRUITS-1:0] fruitShown;  // per slot visibility
    logic [`NUM_FRUITS-1:0] slicePulse;  // per slot new slice

    // ------------------------------------------------------------
    // blade
    // ------------------------------------------------------------

    cursorProbe cursorProbe_inst (
        .Clk        (Clk),
        .resetf0    (resetf0),
        .throwFruit (throwFruit),
        .DrawX      (DrawX),
        .DrawY      (DrawY),
        .BallX      (BallX),
        .BallY      (BallY),
        .BallSize   (BallSize),
        .bladeOn    (bladeOn),
        .playOn     (playOn)
    );

    // ------------------------------------------------------------
    // fruit slots
    // ------------------------------------------------------------

    for (genvar i = 0; i < `NUM_FRUITS; i++)
    begin : gSlot
        fruitSlot fruitSlot_inst (
            .Clk        (Clk),
            .resetf0    (resetf0),
            .bladeOn    (bladeOn),
            .playOn     (playOn),
            .offstage   (offstage[i]),
            .DrawX      (DrawX),
            .DrawY      (DrawY),
            .fruitX     (fruitX[i]),
            .fruitY     (fruitY[i]),
            .fruitSize  (fruitSize[i]),
            .fruitShown (fruitShown[i]),
            .slicePulse (slicePulse[i]),
            .sliced     (sliced[i])
        );
    end

    // ------------------------------------------------------------
    // mixer
    // ------------------------------------------------------------

    sceneMixer sceneMixer_inst (
        .Clk        (Clk),
        .resetf0    (resetf0),
        .bladeOn    (bladeOn),
        .fruitShown (fruitShown),
        .slicePulse (slicePulse),
        .BkgRed     (BkgRed),
        .BkgGreen   (BkgGreen),
        .BkgBlue    (BkgBlue),
        .Red        (Red),
        .Green      (Green),
        .Blue       (Blue),
        .score      (score)
    );

    // background and hit tests assume the scan stays on the visible raster
    pixelOnRaster: assert property (
        @(posedge Clk) disable iff (resetf0)
        (DrawX < `SCREEN_W) && (DrawY < `SCREEN_H)
    );

endmodule

`default_nettype wire

//--- tests/tbChecks.sv
// slicer reference checker
// rebuilds the expected color, sliced flags and score from the input history

`default_nettype none

`include "slicer_cfg.svh"

module tbChecks import slicerPkg::*;
(
    input  logic                   Clk,
    input  logic                   resetf0,
    input  string                  testName,                 // for error lines
    input  coordT                  DrawX,
    input  coordT                  DrawY,
    input  coordT                  BallX,
    input  coordT                  BallY,
    input  radiusT                 BallSize,
    input  coordT                  fruitX    [`NUM_FRUITS],
    input  coordT                  fruitY    [`NUM_FRUITS],
    input  radiusT                 fruitSize [`NUM_FRUITS],
    input  logic [`NUM_FRUITS-1:0] offstage,
    input  logic                   throwFruit,
    input  colorT                  BkgRed,
    input  colorT                  BkgGreen,
    input  colorT                  BkgBlue,
    input  colorT                  Red,                      // DUT outputs
    input  colorT                  Green,
    input  colorT                  Blue,
    input  scoreT                  score,
    input  logic [`NUM_FRUITS-1:0] sliced,
    output int                     errorCount
);

    timeunit 1ns;
    timeprecision 100ps;

    logic                   hBlade;    // previous pixel under blade in play
    logic                   hPlay;     // previous pixel's play level
    logic [`NUM_FRUITS-1:0] hFruit;    // previous pixel inside each fruit
    logic [23:0]            hBkg;      // previous pixel's background
    logic [23:0]            expColor;  // expected output color
    logic [`NUM_FRUITS-1:0] mSliced;   // model sliced flags
    scoreT                  mScore;    // model score

    initial errorCount = 0;

    // plain integer circle test, squares stay well inside 32 bits
    function automatic logic covers(int px, int py, int cx, int cy, int r);
        int dx;
        int dy;
        dx = px - cx;
        dy = py - cy;
        return (dx * dx + dy * dy) <= (r * r);
    endfunction

    function automatic logic [23:0] fruitRgb(int i);
        case (i % 3)
            0:       return {`FRUIT_RED_0, `FRUIT_GREEN_0, `FRUIT_BLUE_0};
            1:       return {`FRUIT_RED_1, `FRUIT_GREEN_1, `FRUIT_BLUE_1};
            default: return {`FRUIT_RED_2, `FRUIT_GREEN_2, `FRUIT_BLUE_2};
        endcase
    endfunction

    // ------------------------------------------------------------
    // reference model, one step per edge
    // ------------------------------------------------------------

    always @(posedge Clk)
    begin : refModel
        logic [23:0]            color;   // color of the previous pixel
        logic [`NUM_FRUITS-1:0] cutNow;  // blade and fruit on that pixel
        logic                   found;   // lowest visible fruit taken
        color = hBkg;
        found = 1'b0;
        for (int i = 0; i < `NUM_FRUITS; i++)
        begin
            if (!found && hPlay && hFruit[i] && !mSliced[i])
            begin
                color = fruitRgb(i);
                found = 1'b1;
            end
        end
        if (hBlade)
        begin
            color = {`CURSOR_RED, `CURSOR_GREEN, `CURSOR_BLUE};  // blade on top
        end
        cutNow = hBlade ? hFruit : '0;
        if (resetf0)
        begin
            expColor <= '0;
            mSliced  <= '0;
            mScore   <= '0;
            hBlade   <= 1'b0;
            hPlay    <= 1'b0;
        end
        else
        begin
            expColor <= color;
            mSliced  <= ~offstage & (mSliced | cutNow);  // leaving beats cutting
            if (|(cutNow & ~mSliced & ~offstage))
            begin
                mScore <= mScore + 1'b1;                 // one per cycle at most
            end
            hBlade <= throwFruit && covers(DrawX, DrawY, BallX, BallY, BallSize);
            hPlay  <= throwFruit;
        end
        hBkg <= {BkgRed, BkgGreen, BkgBlue};
        for (int i = 0; i < `NUM_FRUITS; i++)
        begin
            hFruit[i] <= covers(DrawX, DrawY, fruitX[i], fruitY[i], fruitSize[i]);
        end
    end

    // ------------------------------------------------------------
    // output checks
    // ------------------------------------------------------------

    colorMatches: assert property (
        @(posedge Clk) disable iff (resetf0)
        {Red, Green, Blue} == expColor
    )
    else
    begin
        errorCount = errorCount + 1;
        $display("** Error [%s] color expected %06h actual %06h", testName,
                 $sampled(expColor), $sampled({Red, Green, Blue}));
    end

    slicedMatches: assert property (
        @(posedge Clk) disable iff (resetf0)
        sliced == mSliced
    )
    else
    begin
        errorCount = errorCount + 1;
        $display("** Error [%s] sliced expected %b actual %b", testName,
                 $sampled(mSliced), $sampled(sliced));
    end

    scoreMatches: assert property (
        @(posedge Clk) disable iff (resetf0)
        score == mScore
    )
    else
    begin
        errorCount = errorCount + 1;
        $display("** Error [%s] score expected %0d actual %0d", testName,
                 $sampled(mScore), $sampled(score));
    end

    resetClears: assert property (
        @(posedge Clk)
        resetf0 |=> (sliced == '0) && (score == '0) && ({Red, Green, Blue} == '0)
    )
    else
    begin
        errorCount = errorCount + 1;
        $display("** Error [%s] reset state expected all zero actual sliced %b score %0d color %06h",
                 testName, $sampled(sliced), $sampled(score), $sampled({Red, Green, Blue}));
    end

endmodule

`default_nettype wire

//--- tests/tbTop.sv
// slicer testbench
// drives pixels over blade and fruits in six tests, with timeout and report

`default_nettype none

`include "slicer_cfg.svh"

module tbTop import slicerPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int cycleLimit = 4000;                           // six tests, margin
    localparam int lastFruit  = `NUM_FRUITS - 1;
    localparam int midFruit   = (`NUM_FRUITS > 1) ? 1 : 0;

    logic                   Clk;
    logic                   resetf0;
    coordT                  DrawX;
    coordT                  DrawY;
    coordT                  BallX;
    coordT                  BallY;
    radiusT                 BallSize;
    coordT                  fruitX    [`NUM_FRUITS];
    coordT                  fruitY    [`NUM_FRUITS];
    radiusT                 fruitSize [`NUM_FRUITS];
    logic [`NUM_FRUITS-1:0] offstage;
    logic                   throwFruit;
    colorT                  BkgRed;
    colorT                  BkgGreen;
    colorT                  BkgBlue;
    colorT                  Red;
    colorT                  Green;
    colorT                  Blue;
    scoreT                  score;
    logic [`NUM_FRUITS-1:0] sliced;
    integer                 seed;          // $random state
    int                     cycleCount;
    int                     errorCount;    // counted by the checker
    int                     testCount;
    int                     errorsBefore;  // errors when the test began
    string                  testName;

    sliceTop sliceTop_inst (
        .Clk(Clk), .resetf0(resetf0), .DrawX(DrawX), .DrawY(DrawY),
        .BallX(BallX), .BallY(BallY), .BallSize(BallSize),
        .fruitX(fruitX), .fruitY(fruitY), .fruitSize(fruitSize),
        .offstage(offstage), .throwFruit(throwFruit),
        .BkgRed(BkgRed), .BkgGreen(BkgGreen), .BkgBlue(BkgBlue),
        .Red(Red), .Green(Green), .Blue(Blue), .score(score), .sliced(sliced)
    );

    tbChecks tbChecks_inst (
        .Clk(Clk), .resetf0(resetf0), .testName(testName), .DrawX(DrawX), .DrawY(DrawY),
        .BallX(BallX), .BallY(BallY), .BallSize(BallSize),
        .fruitX(fruitX), .fruitY(fruitY), .fruitSize(fruitSize),
        .offstage(offstage), .throwFruit(throwFruit),
        .BkgRed(BkgRed), .BkgGreen(BkgGreen), .BkgBlue(BkgBlue),
        .Red(Red), .Green(Green), .Blue(Blue), .score(score), .sliced(sliced),
        .errorCount(errorCount)
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;  // 10 ns period
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Regression failed");
        $finish;
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    task automatic waitCycle();
        @(posedge Clk);
        #1;                                         // inputs move after the edge
    endtask

    task automatic drivePixel(int x, int y);
        waitCycle();
        DrawX    = coordT'(x);
        DrawY    = coordT'(y);
        BkgRed   = colorT'($random(seed));           // noisy background
        BkgGreen = colorT'($random(seed));
        BkgBlue  = colorT'($random(seed));
    endtask

    // centers sit far enough inside the raster for any span used here
    task automatic scanNear(int cx, int cy, int span, int count);
        int dx;
        int dy;
        for (int k = 0; k < count; k++)
        begin
            dx = $random(seed) % (span + 1);
            dy = $random(seed) % (span + 1);
            drivePixel(cx + dx, cy + dy);
        end
    endtask

    task automatic placeBlade(int x, int y, int r);
        BallX    = coordT'(x);
        BallY    = coordT'(y);
        BallSize = radiusT'(r);
    endtask

    task automatic startTest(string name);
        testName     = name;
        errorsBefore = errorCount;
    endtask

    task automatic finishTest();
        repeat (3) waitCycle();                     // drain the two-stage pipe
        $display("test %-14s done, %0d errors", testName, errorCount - errorsBefore);
        testCount++;
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial
    begin
        seed       = 32'h43f10105;
        testCount  = 0;
        testName   = "init";
        resetf0    = 1'b1;
        throwFruit = 1'b0;
        offstage   = '0;
        DrawX      = '0;
        DrawY      = '0;
        BkgRed     = '0;
        BkgGreen   = '0;
        BkgBlue    = '0;
        placeBlade(600, 440, 4);
        for (int i = 0; i < `NUM_FRUITS; i++)
        begin
            fruitX[i]    = coordT'(100 + 60 * i);   // neighbours overlap
            fruitY[i]    = coordT'(120 + 20 * (i % 2));
            fruitSize[i] = radiusT'(35);
        end

        startTest("resetState");
        repeat (8) waitCycle();
        resetf0 = 1'b0;
        scanNear(320, 240, 200, 20);
        finishTest();

        startTest("idlePlay");                      // blade over fruit, no play
        placeBlade(fruitX[0], fruitY[0], 20);
        scanNear(fruitX[0], fruitY[0], 60, 200);
        finishTest();

        startTest("bladePriority");
        throwFruit = 1'b1;
        placeBlade(fruitX[lastFruit], fruitY[lastFruit], 15);
        scanNear(fruitX[lastFruit], fruitY[lastFruit], 40, 200);
        finishTest();

        startTest("fruitDrawing");                  // blade parked in a corner
        placeBlade(600, 440, 4);
        scanNear(130, 130, 60, 250);
        finishTest();

        startTest("slicing");
        placeBlade(fruitX[midFruit], fruitY[midFruit], 10);
        scanNear(fruitX[midFruit], fruitY[midFruit], 45, 200);
        finishTest();

        startTest("offstage");
        placeBlade(fruitX[0], fruitY[0], 20);
        for (int k = 0; k < 300; k++)
        begin
            if (k % 25 == 23)
            begin
                drivePixel(fruitX[0], fruitY[0]);   // sure cut right before recycle
            end
            else
            begin
                scanNear(fruitX[0], fruitY[0], 30, 1);
            end
            offstage = (k % 25 == 24) ? '1 : '0;  // one-cycle recycle
        end
        offstage = '0;
        finishTest();

        $display("tests run %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/slicerPkg.sv
verilog/cursorProbe.sv
verilog/fruitSlot.sv
verilog/sceneMixer.sv
verilog/sliceTop.sv
tests/tbChecks.sv
tests/tbTop.sv

//--- Bender.yml
package:
  name: slicer

export_include_dirs:
  - verilog

sources:
  - verilog/slicerPkg.sv
  - verilog/cursorProbe.sv
  - verilog/fruitSlot.sv
  - verilog/sceneMixer.sv
  - verilog/sliceTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tbChecks.sv
      - tests/tbTop.sv
